// ==== common/pixel_buf_if.sv ====
interface pixel_buf_if;

    // show-ahead head of the line buffer
    video_pkg::buf_entry_t rd_entry;
    logic                  empty;
    // consume head this cycle
    logic                  pop;
    // one pulse per popped entry, goes back to the source
    logic                  credit_return;

    modport buf_side (
        output rd_entry,
        output empty,
        output credit_return,
        input  pop
    );

    modport ctrl_side (
        input  rd_entry,
        input  empty,
        output pop
    );

endinterface

// ==== common/video_config.svh ====
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// horizontal raster, in pixels
`define H_ACTIVE 16
`define H_FRONT 2
`define H_SYNC 3
`define H_BACK 3
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical raster, in lines
`define V_ACTIVE 4
`define V_FRONT 1
`define V_SYNC 2
`define V_BACK 1
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// line buffer size, also the source's starting credit count
`define LINE_BUF_DEPTH 32
`define LINE_BUF_AW 5

`endif

// ==== common/video_pkg.sv ====
package video_pkg;

    // ************************************************************
    // pixel and line buffer word
    // ************************************************************

    // red in the top byte, same order as the stream tdata
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_t;

    // one line buffer word, pixel plus end of line flag
    typedef struct packed {
        pixel_t pixel;
        logic   last;
    } buf_entry_t;

    // ************************************************************
    // stream controller states
    // ************************************************************

    typedef enum logic [1:0] {
        SEEK,
        WAIT_LINE,
        STREAM,
        DRAIN
    } ctrl_state_t;

endpackage

// ==== compile.f ====
+incdir+common
common/video_pkg.sv
common/pixel_buf_if.sv
logic/video_timing.sv
logic/line_buffer.sv
logic/stream_ctrl.sv
tmds/tmds_encoder.sv
logic/hdmi_tx_top.sv
sim/tb_hdmi_tx.sv

// ==== logic/hdmi_tx_top.sv ====
module hdmi_tx_top (
    input  logic        pixel_clk,
    input  logic        arst_n,
    input  logic [23:0] s_tdata,
    input  logic        s_tvalid,
    input  logic        s_tlast,
    output logic        credit_return,
    output logic [9:0]  tmds_ch0,
    output logic [9:0]  tmds_ch1,
    output logic [9:0]  tmds_ch2,
    output logic        sync_error
);

    video_pkg::buf_entry_t wr_entry;
    video_pkg::pixel_t     enc_pixel;
    logic                  hsync;
    logic                  vsync;
    logic                  de;
    logic                  line_start;
    logic                  line_end;
    logic                  enc_hsync;
    logic                  enc_vsync;
    logic                  enc_de;

    pixel_buf_if pix_buf ();

    // stream beat into one buffer word
    assign wr_entry.pixel = video_pkg::pixel_t'(s_tdata);
    assign wr_entry.last  = s_tlast;
    assign credit_return  = pix_buf.credit_return;

    // ************************************************************
    // raster, buffer, controller
    // ************************************************************

    video_timing u_timing (
        .pixel_clk  (pixel_clk),
        .arst_n     (arst_n),
        .hsync      (hsync),
        .vsync      (vsync),
        .de         (de),
        .line_start (line_start),
        .line_end   (line_end)
    );

    line_buffer u_line_buf (
        .pixel_clk (pixel_clk),
        .arst_n    (arst_n),
        .wr_data   (wr_entry),
        .wr_valid  (s_tvalid),
        .rd        (pix_buf.buf_side)
    );

    stream_ctrl u_ctrl (
        .pixel_clk  (pixel_clk),
        .arst_n     (arst_n),
        .hsync      (hsync),
        .vsync      (vsync),
        .de         (de),
        .line_start (line_start),
        .line_end   (line_end),
        .buf_if     (pix_buf.ctrl_side),
        .enc_pixel  (enc_pixel),
        .enc_hsync  (enc_hsync),
        .enc_vsync  (enc_vsync),
        .enc_de     (enc_de),
        .sync_error (sync_error)
    );

    // ************************************************************
    // tmds channels, syncs ride on blue only
    // ************************************************************

    tmds_encoder u_enc_blue (
        .pixel_clk (pixel_clk),
        .arst_n    (arst_n),
        .data      (enc_pixel.blue),
        .c0        (enc_hsync),
        .c1        (enc_vsync),
        .de        (enc_de),
        .symbol    (tmds_ch0)
    );

    tmds_encoder u_enc_green (
        .pixel_clk (pixel_clk),
        .arst_n    (arst_n),
        .data      (enc_pixel.green),
        .c0        (1'b0),
        .c1        (1'b0),
        .de        (enc_de),
        .symbol    (tmds_ch1)
    );

    tmds_encoder u_enc_red (
        .pixel_clk (pixel_clk),
        .arst_n    (arst_n),
        .data      (enc_pixel.red),
        .c0        (1'b0),
        .c1        (1'b0),
        .de        (enc_de),
        .symbol    (tmds_ch2)
    );

endmodule

// ==== logic/line_buffer.sv ====
`include "video_config.svh"

module line_buffer (
    input  logic                  pixel_clk,
    input  logic                  arst_n,
    input  video_pkg::buf_entry_t wr_data,
    input  logic                  wr_valid,
    pixel_buf_if.buf_side         rd
);

    localparam int             AW       = `LINE_BUF_AW;
    localparam int             DEPTH    = `LINE_BUF_DEPTH;
    localparam logic [AW-1:0]  LAST_IDX = AW'(DEPTH - 1);
    localparam logic [AW:0]    FULL_CNT = (AW + 1)'(DEPTH);

    video_pkg::buf_entry_t mem [DEPTH];
    logic [AW-1:0]         wr_ptr;
    logic [AW-1:0]         rd_ptr;
    logic [AW:0]           fill;
    logic                  full;
    logic                  do_pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        // wrap at depth, depth need not be a power of two
        return (ptr == LAST_IDX) ? '0 : ptr + 1'b1;
    endfunction

    assign full        = (fill == FULL_CNT);
    assign rd.empty    = (fill == '0);
    // show-ahead head word
    assign rd.rd_entry = mem[rd_ptr];
    assign do_pop      = rd.pop && !rd.empty;

    // ************************************************************
    // storage
    // ************************************************************

    // credit rule guarantees room, so every beat is written
    always_ff @(posedge pixel_clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // ************************************************************
    // pointers, fill count, credit pulse
    // ************************************************************

    always_ff @(posedge pixel_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr           <= '0;
            rd_ptr           <= '0;
            fill             <= '0;
            rd.credit_return <= 1'b0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // simultaneous push and pop leaves fill alone
            case ({wr_valid, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // one credit back per released entry
            rd.credit_return <= do_pop;
        end
    end

    // source spent a credit it did not hold
    no_write_when_full: assert property (@(posedge pixel_clk) disable iff (!arst_n)
        wr_valid |-> !full);

    // controller must look at empty before popping
    no_pop_when_empty: assert property (@(posedge pixel_clk) disable iff (!arst_n)
        rd.pop |-> !rd.empty);

endmodule

// ==== logic/stream_ctrl.sv ====
module stream_ctrl (
    input  logic              pixel_clk,
    input  logic              arst_n,
    input  logic              hsync,
    input  logic              vsync,
    input  logic              de,
    input  logic              line_start,
    input  logic              line_end,
    pixel_buf_if.ctrl_side    buf_if,
    output video_pkg::pixel_t enc_pixel,
    output logic              enc_hsync,
    output logic              enc_vsync,
    output logic              enc_de,
    output logic              sync_error
);

    video_pkg::ctrl_state_t state;
    video_pkg::ctrl_state_t state_nxt;
    video_pkg::pixel_t      pix_nxt;
    logic                   err_set;
    logic                   streaming;

    // first pixel of a line is served while WAIT_LINE hands over
    assign streaming = (state == video_pkg::STREAM) ||
                       ((state == video_pkg::WAIT_LINE) && line_start);

    // ************************************************************
    // next state, pop, pixel select
    // ************************************************************

    always_comb begin
        state_nxt   = state;
        pix_nxt     = '0;
        buf_if.pop  = 1'b0;
        err_set     = 1'b0;
        case (state)
            video_pkg::SEEK, video_pkg::DRAIN: begin
                // throw entries away up to a line boundary
                if (!buf_if.empty) begin
                    buf_if.pop = 1'b1;
                    if (buf_if.rd_entry.last) begin
                        state_nxt = video_pkg::WAIT_LINE;
                    end
                end
            end
            video_pkg::WAIT_LINE, video_pkg::STREAM: begin
                if (streaming && de) begin
                    state_nxt = video_pkg::STREAM;
                    if (!buf_if.empty) begin
                        buf_if.pop = 1'b1;
                        pix_nxt    = buf_if.rd_entry.pixel;
                        if (line_end && buf_if.rd_entry.last) begin
                            // line lengths agree
                            state_nxt = video_pkg::WAIT_LINE;
                        end else if (line_end || buf_if.rd_entry.last) begin
                            // last too early or missing
                            err_set   = 1'b1;
                            state_nxt = video_pkg::DRAIN;
                        end
                    end else if (line_end) begin
                        // starved at line end means the rest of this line is late
                        state_nxt = video_pkg::DRAIN;
                    end
                end
            end
            default: state_nxt = video_pkg::SEEK;
        endcase
    end

    // ************************************************************
    // registered encoder side
    // ************************************************************

    always_ff @(posedge pixel_clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= video_pkg::SEEK;
            sync_error <= 1'b0;
            enc_de     <= 1'b0;
            enc_hsync  <= 1'b0;
            enc_vsync  <= 1'b0;
        end else begin
            state      <= state_nxt;
            // sticky
            sync_error <= sync_error | err_set;
            enc_de     <= de;
            enc_hsync  <= hsync;
            enc_vsync  <= vsync;
        end
    end

    // black unless a pixel was popped in de
    always_ff @(posedge pixel_clk) begin
        enc_pixel <= pix_nxt;
    end

    // a pop while waiting only takes the first active pixel of a line
    no_pop_while_waiting: assert property (@(posedge pixel_clk) disable iff (!arst_n)
        ((state == video_pkg::WAIT_LINE) && buf_if.pop) |-> (de && !$past(de)));

endmodule

// ==== logic/video_timing.sv ====
`include "video_config.svh"

module video_timing (
    input  logic pixel_clk,
    input  logic arst_n,
    output logic hsync,
    output logic vsync,
    output logic de,
    output logic line_start,
    output logic line_end
);

    localparam int H_W        = $clog2(`H_TOTAL);
    localparam int V_W        = $clog2(`V_TOTAL);
    // active first, then front porch, sync, back porch
    localparam int H_SYNC_BEG = `H_ACTIVE + `H_FRONT;
    localparam int H_SYNC_END = H_SYNC_BEG + `H_SYNC;
    localparam int V_SYNC_BEG = `V_ACTIVE + `V_FRONT;
    localparam int V_SYNC_END = V_SYNC_BEG + `V_SYNC;

    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    logic           h_wrap;
    logic           h_active;
    logic           v_active;

    assign h_wrap = (int'(h_cnt) == `H_TOTAL - 1);

    // ************************************************************
    // raster counters
    // ************************************************************

    always_ff @(posedge pixel_clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_wrap) begin
            h_cnt <= '0;
            // frame wrap
            if (int'(v_cnt) == `V_TOTAL - 1) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // ************************************************************
    // window decode
    // ************************************************************

    assign h_active   = (int'(h_cnt) < `H_ACTIVE);
    assign v_active   = (int'(v_cnt) < `V_ACTIVE);
    assign de         = h_active && v_active;
    // syncs active high
    assign hsync      = (int'(h_cnt) >= H_SYNC_BEG) && (int'(h_cnt) < H_SYNC_END);
    assign vsync      = (int'(v_cnt) >= V_SYNC_BEG) && (int'(v_cnt) < V_SYNC_END);
    // markers only on active lines
    assign line_start = v_active && (h_cnt == '0);
    assign line_end   = v_active && (int'(h_cnt) == `H_ACTIVE - 1);

    counters_in_range: assert property (@(posedge pixel_clk) disable iff (!arst_n)
        (int'(h_cnt) < `H_TOTAL) && (int'(v_cnt) < `V_TOTAL));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_hdmi_tx -Mdir obj_dir -f compile.f

./obj_dir/Vtb_hdmi_tx > sim.log 2>&1 || true
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
    exit 0
else
    exit 1
fi

// ==== sim/tb_hdmi_tx.sv ====
`include "video_config.svh"

module tb_hdmi_tx;

    localparam int PERIOD   = 4;
    localparam int N_LINES  = 20;
    // DVI control codes, indexed by {c1, c0}
    localparam logic [9:0] CTRL_00 = 10'b1101010100;
    localparam logic [9:0] CTRL_01 = 10'b0010101011;
    localparam logic [9:0] CTRL_10 = 10'b0101010100;
    localparam logic [9:0] CTRL_11 = 10'b1010101011;

    logic        pixel_clk;
    logic        arst_n;
    logic [23:0] s_tdata;
    logic        s_tvalid;
    logic        s_tlast;
    logic        credit_return;
    logic [9:0]  tmds_ch0;
    logic [9:0]  tmds_ch1;
    logic [9:0]  tmds_ch2;
    logic        sync_error;

    integer      seed = 32'h8b9f55f0;
    logic [23:0] model_q[$];
    int          credits;
    int          beats_sent;
    int          credits_back;
    bit          checking;
    bit          err_phase;
    // decoded raster state
    int          data_run;
    int          hs_run;
    int          vs_run;
    int          lines_seen;
    int          vs_count;
    bit          prev_de;
    bit          prev_hs;
    bit          prev_vs;
    bit          err_seen;
    int          disp[3];
    logic [9:0]  sym[3];
    logic [7:0]  byte_dec[3];
    logic [23:0] px;
    bit          hs;
    bit          vs;

    hdmi_tx_top DUT (
        .pixel_clk     (pixel_clk),
        .arst_n        (arst_n),
        .s_tdata       (s_tdata),
        .s_tvalid      (s_tvalid),
        .s_tlast       (s_tlast),
        .credit_return (credit_return),
        .tmds_ch0      (tmds_ch0),
        .tmds_ch1      (tmds_ch1),
        .tmds_ch2      (tmds_ch2),
        .sync_error    (sync_error)
    );

    initial begin
        pixel_clk = 1'b0;
        forever #(PERIOD / 2) pixel_clk = ~pixel_clk;
    end

    // ************************************************************
    // helpers
    // ************************************************************

    task automatic stop_on_error;
        $display("Finished with errors");
        $fatal(1, "stopping at first error");
    endtask

    function automatic bit is_control(input logic [9:0] s);
        return (s == CTRL_00) || (s == CTRL_01) || (s == CTRL_10) || (s == CTRL_11);
    endfunction

    function automatic int count_ones(input logic [9:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 10; i++) begin
            n += v[i];
        end
        return n;
    endfunction

    // undo the inversion, then the xor or xnor chain
    function automatic logic [7:0] decode_byte(input logic [9:0] s);
        logic [7:0] d;
        logic [7:0] b;
        d    = s[9] ? ~s[7:0] : s[7:0];
        b[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            b[i] = s[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
        end
        return b;
    endfunction

    // bit 8 must match the xnor rule of the decoded byte
    function automatic bit xor_flag_ok(input logic [9:0] s, input logic [7:0] b);
        int  n;
        bit  want_xnor;
        n         = count_ones({2'b00, b});
        want_xnor = (n > 4) || ((n == 4) && !b[0]);
        return s[8] == !want_xnor;
    endfunction

    // one cycle of the source, counts the credit returned at this edge
    task automatic tick;
        @(posedge pixel_clk);
        #1;
        s_tvalid = 1'b0;
        if (credit_return) begin
            credits++;
            credits_back++;
        end
        assert (credits_back <= beats_sent) else begin
            $display("more credits returned (%0d) than beats sent (%0d)",
                     credits_back, beats_sent);
            stop_on_error();
        end
    endtask

    task automatic send_beat(input logic [23:0] pix, input logic last, input bit gaps,
                             input bit to_model);
        bit done;
        done = 1'b0;
        while (!done) begin
            tick();
            if (credits > 0 && (!gaps || ($random(seed) & 7) != 0)) begin
                s_tdata  = pix;
                s_tlast  = last;
                s_tvalid = 1'b1;
                credits--;
                beats_sent++;
                if (to_model) begin
                    model_q.push_back(pix);
                end
                done = 1'b1;
            end
        end
    endtask

    // ************************************************************
    // output monitor, decoder model and scoreboard
    // ************************************************************

    always @(negedge pixel_clk) begin
        if (arst_n) begin
            sym[0] = tmds_ch0;
            sym[1] = tmds_ch1;
            sym[2] = tmds_ch2;
            if (is_control(sym[0])) begin
                assert (sym[1] == CTRL_00 && sym[2] == CTRL_00) else begin
                    $display("mismatch at %0t: tmds_ch1/ch2 expected %h got %h/%h",
                             $time, CTRL_00, sym[1], sym[2]);
                    stop_on_error();
                end
                disp = '{0, 0, 0};
                hs   = (sym[0] == CTRL_01) || (sym[0] == CTRL_11);
                vs   = (sym[0] == CTRL_10) || (sym[0] == CTRL_11);
                if (prev_de) begin
                    assert (data_run == `H_ACTIVE) else begin
                        $display("mismatch at %0t: data symbols per line expected %0d got %0d",
                                 $time, `H_ACTIVE, data_run);
                        stop_on_error();
                    end
                    data_run = 0;
                    lines_seen++;
                end
                prev_de = 1'b0;
            end else begin
                hs = 1'b0;
                vs = 1'b0;
                for (int c = 0; c < 3; c++) begin
                    assert (!is_control(sym[c])) else begin
                        $display("channel %0d sent a control symbol during data", c);
                        stop_on_error();
                    end
                    byte_dec[c] = decode_byte(sym[c]);
                    assert (xor_flag_ok(sym[c], byte_dec[c])) else begin
                        $display("channel %0d symbol %h does not decode to a valid byte",
                                 c, sym[c]);
                        stop_on_error();
                    end
                    disp[c] += 2 * count_ones(sym[c]) - 10;
                    assert (disp[c] >= -10 && disp[c] <= 10) else begin
                        $display("channel %0d disparity left the range: %0d", c, disp[c]);
                        stop_on_error();
                    end
                end
                data_run++;
                prev_de = 1'b1;
                // red, green, blue as on s_tdata
                px = {byte_dec[2], byte_dec[1], byte_dec[0]};
                if (checking) begin
                    assert ((model_q.size() == 0 && px == '0) ||
                            (model_q.size() != 0 && px == model_q[0])) else begin
                        $display("mismatch at %0t: pixel expected %h got %h", $time,
                                 (model_q.size() != 0) ? model_q[0] : 24'h0, px);
                        stop_on_error();
                    end
                    if (model_q.size() != 0) begin
                        void'(model_q.pop_front());
                    end
                end
            end
            // hsync width in symbols
            if (hs) begin
                hs_run++;
            end else if (prev_hs) begin
                assert (hs_run == `H_SYNC) else begin
                    $display("mismatch at %0t: hsync width expected %0d got %0d",
                             $time, `H_SYNC, hs_run);
                    stop_on_error();
                end
                hs_run = 0;
            end
            // vsync width, and active lines between pulses
            if (vs) begin
                if (!prev_vs && vs_count > 0) begin
                    assert (lines_seen == `V_ACTIVE) else begin
                        $display("mismatch at %0t: lines per frame expected %0d got %0d",
                                 $time, `V_ACTIVE, lines_seen);
                        stop_on_error();
                    end
                end
                if (!prev_vs) begin
                    lines_seen = 0;
                end
                vs_run++;
            end else if (prev_vs) begin
                assert (vs_run == `V_SYNC * `H_TOTAL) else begin
                    $display("mismatch at %0t: vsync width expected %0d got %0d",
                             $time, `V_SYNC * `H_TOTAL, vs_run);
                    stop_on_error();
                end
                vs_run = 0;
                vs_count++;
            end
            prev_hs = hs;
            prev_vs = vs;
            // sticky error, only allowed once the bad line is sent
            assert (!sync_error || err_phase) else begin
                $display("sync_error rose during the clean stream");
                stop_on_error();
            end
            assert (!err_seen || sync_error) else begin
                $display("sync_error fell after it was set");
                stop_on_error();
            end
            if (sync_error) begin
                err_seen = 1'b1;
            end
        end
    end

    // ************************************************************
    // stimulus
    // ************************************************************

    initial begin
        int vs_mark;
        arst_n       = 1'b0;
        s_tdata      = '0;
        s_tvalid     = 1'b0;
        s_tlast      = 1'b0;
        credits      = `LINE_BUF_DEPTH;
        beats_sent   = 0;
        credits_back = 0;
        checking     = 1'b1;
        err_phase    = 1'b0;
        repeat (8) @(posedge pixel_clk);
        #1;
        arst_n = 1'b1;
        // idle outputs right after reset
        repeat (2) begin
            @(negedge pixel_clk);
            assert (is_control(tmds_ch0) && is_control(tmds_ch1) && is_control(tmds_ch2)
                    && !credit_return && !sync_error) else begin
                $display("outputs not idle after reset");
                stop_on_error();
            end
        end
        repeat (2) tick();
        // first line is thrown away while the controller seeks
        for (int p = 0; p < N_LINES * `H_ACTIVE; p++) begin
            send_beat(24'($random(seed)), (p % `H_ACTIVE) == `H_ACTIVE - 1,
                      p >= 2 * `H_ACTIVE, p >= `H_ACTIVE);
        end
        while (model_q.size() != 0) begin
            tick();
        end
        repeat (4) tick();
        assert (credits == `LINE_BUF_DEPTH) else begin
            $display("mismatch at %0t: credits expected %0d got %0d",
                     $time, `LINE_BUF_DEPTH, credits);
            stop_on_error();
        end
        // bad line starts after a vsync pulse so the buffer leads the raster
        checking  = 1'b0;
        err_phase = 1'b1;
        vs_mark   = vs_count;
        while (vs_count == vs_mark) begin
            tick();
        end
        for (int p = 0; p < 3 * `H_ACTIVE - 1; p++) begin
            send_beat(24'($random(seed)),
                      (p == `H_ACTIVE - 2) || ((p + 1) % `H_ACTIVE) == `H_ACTIVE - 1,
                      1'b0, 1'b0);
        end
        while (!err_seen) begin
            tick();
        end
        // data keeps decoding and the error holds
        repeat (`H_TOTAL * `V_TOTAL) tick();
        $display("Finished with no errors");
        $finish;
    end

    initial begin
        #(`H_TOTAL * `V_TOTAL * 12 * PERIOD);
        $display("timeout: the run did not reach its end in time");
        stop_on_error();
    end

endmodule

// ==== tmds/tmds_encoder.sv ====
module tmds_encoder (
    input  logic       pixel_clk,
    input  logic       arst_n,
    input  logic [7:0] data,
    input  logic       c0,
    input  logic       c1,
    input  logic       de,
    output logic [9:0] symbol
);

    // control symbols indexed by {c1, c0}
    localparam logic [9:0] CTRL_00 = 10'b1101010100;
    localparam logic [9:0] CTRL_01 = 10'b0010101011;
    localparam logic [9:0] CTRL_10 = 10'b0101010100;
    localparam logic [9:0] CTRL_11 = 10'b1010101011;

    logic [3:0]        n1_d;
    logic              use_xnor;
    logic [8:0]        q_m;
    logic [3:0]        n1_q;
    logic [3:0]        n0_q;
    logic signed [4:0] balance;
    logic signed [4:0] disp;
    logic signed [4:0] disp_nxt;
    logic [9:0]        sym_nxt;

    function automatic logic [3:0] ones8(input logic [7:0] v);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < 8; i++) begin
            n = n + {3'b000, v[i]};
        end
        return n;
    endfunction

    // ************************************************************
    // stage 1, transition minimization
    // ************************************************************

    assign n1_d     = ones8(data);
    assign use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !data[0]);

    always_comb begin
        q_m[0] = data[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
        end
        // bit 8 flags xor
        q_m[8] = ~use_xnor;
    end

    // ************************************************************
    // stage 2, dc balance
    // ************************************************************

    assign n1_q    = ones8(q_m[7:0]);
    assign n0_q    = 4'd8 - n1_q;
    // ones minus zeros of q_m[7:0]
    assign balance = $signed({1'b0, n1_q}) - $signed({1'b0, n0_q});

    always_comb begin
        sym_nxt  = CTRL_00;
        disp_nxt = disp;
        if (!de) begin
            // blanking restarts the running disparity
            disp_nxt = '0;
            case ({c1, c0})
                2'b00:   sym_nxt = CTRL_00;
                2'b01:   sym_nxt = CTRL_01;
                2'b10:   sym_nxt = CTRL_10;
                default: sym_nxt = CTRL_11;
            endcase
        end else if ((disp == 0) || (n1_q == n0_q)) begin
            sym_nxt  = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disp_nxt = q_m[8] ? disp + balance : disp - balance;
        end else if (((disp > 0) && (n1_q > n0_q)) || ((disp < 0) && (n0_q > n1_q))) begin
            // invert to pull disparity back
            sym_nxt  = {1'b1, q_m[8], ~q_m[7:0]};
            disp_nxt = disp - balance + (q_m[8] ? 5'sd2 : 5'sd0);
        end else begin
            sym_nxt  = {1'b0, q_m[8], q_m[7:0]};
            disp_nxt = disp + balance - (q_m[8] ? 5'sd0 : 5'sd2);
        end
    end

    always_ff @(posedge pixel_clk or negedge arst_n) begin
        if (!arst_n) begin
            symbol <= CTRL_00;
            disp   <= '0;
        end else begin
            symbol <= sym_nxt;
            disp   <= disp_nxt;
        end
    end

    disparity_bounded: assert property (@(posedge pixel_clk) disable iff (!arst_n)
        (disp >= -5'sd10) && (disp <= 5'sd10));

endmodule
